// File: compile.f
+incdir+include
rtl/pd_pkg.sv
rtl/pd_wr_if.sv
rtl/pd_controller.sv
rtl/pd_byte_counter.sv
rtl/pd_block_buffer.sv
rtl/packet_decoder.sv
sim/tb_packet_decoder.sv

// File: Makefile
# Verilator flow for the packet decoder
VERILATOR ?= verilator
TOP ?= tb_packet_decoder
LOG ?= sim.log
OBJ_DIR ?= obj_dir
FILELIST ?= compile.f
VFLAGS ?= --timing --timescale 1ns/100ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST OK" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_packet_decoder.sv
`default_nettype none

`include "pd_cfg.svh"

module tb_packet_decoder;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int KIND_IN = 0;
	localparam int KIND_OUT = 1;
	localparam int KIND_DATA0 = 2;
	localparam int KIND_DATA1 = 3;
	localparam int DEV = int'(`PD_DEV_ADDR);
	localparam int HASH = int'(`PD_TYPE_HASH);
	localparam int INTR = int'(`PD_TYPE_INTERRUPT);
	localparam int PKT = `PD_PKT_BYTES;
	localparam int N_ROWS = 13;

	typedef struct packed {
		int kind;
		int addr;
		int dtype;
		int corrupt; // Breaks the PID nibble check
		int mem; // 1 store lower, 2 store upper, 3 read whole buffer
		int pulses; // One nibble each for host_ready ack nack p_error quit_hash
		int block_ready;
	} row_t;

	logic clk;
	logic n_rst;
	logic i_rx_strobe;
	logic [7:0] i_rx_data;
	logic i_eop;
	pd_pkg::byte_idx_t i_rd_addr;
	logic [7:0] o_rd_data;
	logic o_host_ready;
	logic o_ack;
	logic o_nack;
	logic o_p_error;
	logic o_quit_hash;
	logic o_block_ready;

	row_t rows [N_ROWS];
	logic [7:0] model [`PD_BLOCK_BYTES];
	logic [7:0] payload [PKT];
	int cnt [5] = '{default: 0};
	int fall_cnt [5]; // Counts when i_eop falls
	integer seed = 32'he4fc;
	string pulse_name [5] = '{"o_host_ready", "o_ack", "o_nack", "o_p_error", "o_quit_hash"};

	packet_decoder packet_decoder_inst (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Count pulses at the falling edge
	always @(negedge clk) begin
		if (o_host_ready) cnt[0]++;
		if (o_ack) cnt[1]++;
		if (o_nack) cnt[2]++;
		if (o_p_error) cnt[3]++;
		if (o_quit_hash) cnt[4]++;
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
			stop_on_error($sformatf("[FAIL] %s got %0h expected %0h", name, got, expected));
	endtask

	function automatic int expected_count(input row_t r, input int k);
		return (r.pulses >> (4 * (4 - k))) & 'hf;
	endfunction

	function automatic int pulses_since(input int base [5]);
		int k;
		int sum;
		sum = 0;
		for (k = 0; k < 5; k++)
			sum += cnt[k] - base[k];
		return sum;
	endfunction

	task automatic send_byte(input logic [7:0] b);
		i_rx_data = b;
		i_rx_strobe = 1'b1;
		next_cycle();
		i_rx_strobe = 1'b0;
		repeat (2) next_cycle(); // Strobes three cycles apart
	endtask

	task automatic send_packet(input row_t r);
		logic [7:0] pid;
		int i;
		case (r.kind)
			KIND_IN: pid = `PD_PID_IN;
			KIND_OUT: pid = `PD_PID_OUT;
			KIND_DATA0: pid = `PD_PID_DATA0;
			default: pid = `PD_PID_DATA1;
		endcase
		send_byte((r.corrupt != 0) ? (pid ^ 8'h01) : pid);
		if (r.kind == KIND_IN || r.kind == KIND_OUT)
			send_byte({r.addr[6:0], 1'b0});
		if (r.kind == KIND_DATA0)
			send_byte(r.dtype[7:0]);
		if (r.kind == KIND_DATA1 || (r.kind == KIND_DATA0 && r.dtype == HASH)) begin
			for (i = 0; i < PKT; i++)
				send_byte(payload[i]);
		end
		i_eop = 1'b1;
		repeat (3) next_cycle();
		fall_cnt = cnt;
		i_eop = 1'b0;
		next_cycle();
	endtask

	task automatic read_back(input int lo, input int hi);
		int a;
		for (a = lo; a <= hi; a++) begin
			next_cycle();
			i_rd_addr = pd_pkg::byte_idx_t'(a);
			#1;
			check_value($sformatf("o_rd_data[%0d]", a), 32'(o_rd_data), 32'(model[a]));
		end
	endtask

	task automatic run_row(input int n);
		row_t r;
		int base [5];
		int expect_all;
		int cycles;
		int k;
		r = rows[n];
		base = cnt;
		expect_all = 0;
		for (k = 0; k < 5; k++)
			expect_all += expected_count(r, k);
		for (k = 0; k < PKT; k++)
			payload[k] = 8'($random(seed));
		next_cycle();
		send_packet(r);
		cycles = 0;
		while (pulses_since(base) < expect_all && cycles < 200) begin
			next_cycle();
			cycles++;
		end
		if (pulses_since(base) < expect_all)
			stop_on_error($sformatf("Row %0d: expected pulse did not arrive", n));
		repeat (10) next_cycle(); // Room for stray pulses
		for (k = 0; k < 5; k++)
			check_value($sformatf("%s pulses, row %0d", pulse_name[k], n),
				cnt[k] - base[k], expected_count(r, k));
		// Host ready while i_eop is high, ack and the last nack after it falls
		check_value($sformatf("o_host_ready pulses before i_eop falls, row %0d", n),
			fall_cnt[0] - base[0], expected_count(r, 0));
		check_value($sformatf("o_ack pulses before i_eop falls, row %0d", n),
			fall_cnt[1] - base[1], 0);
		check_value($sformatf("o_nack pulses before i_eop falls, row %0d", n),
			fall_cnt[2] - base[2], expected_count(r, 3));
		check_value("o_block_ready", 32'(o_block_ready), r.block_ready);
		for (k = 0; k < PKT; k++) begin
			if (r.mem == 1)
				model[k] = payload[k];
			if (r.mem == 2)
				model[k + PKT] = payload[k];
		end
		if (r.mem == 1)
			read_back(0, PKT - 1);
		else if (r.mem == 2)
			read_back(PKT, 2 * PKT - 1);
		else if (r.mem == 3)
			read_back(0, 2 * PKT - 1);
	endtask

	initial begin
		int n;
		n_rst = 1'b0;
		i_rx_strobe = 1'b0;
		i_rx_data = '0;
		i_eop = 1'b0;
		i_rd_addr = '0;
		// kind, address, type, corrupt, mem, pulses, block_ready
		rows[0] = '{KIND_IN, DEV, HASH, 0, 0, 'h10000, 0};
		rows[1] = '{KIND_IN, 'h12, HASH, 0, 0, 'h00000, 0};
		rows[2] = '{KIND_DATA0, DEV, HASH, 0, 0, 'h00000, 0}; // No valid OUT yet
		rows[3] = '{KIND_OUT, 'h12, HASH, 0, 0, 'h00000, 0};
		rows[4] = '{KIND_DATA0, DEV, HASH, 0, 0, 'h00000, 0};
		rows[5] = '{KIND_OUT, DEV, HASH, 0, 0, 'h00000, 0};
		rows[6] = '{KIND_DATA0, DEV, HASH, 0, 1, 'h01001, 0};
		rows[7] = '{KIND_DATA1, DEV, HASH, 0, 2, 'h01001, 1};
		rows[8] = '{KIND_DATA0, DEV, HASH, 1, 3, 'h00210, 1};
		rows[9] = '{KIND_DATA0, DEV, INTR, 0, 3, 'h01002, 1};
		rows[10] = '{KIND_DATA0, DEV, 'h5a, 0, 3, 'h00211, 1}; // Unknown data type
		rows[11] = '{KIND_DATA0, DEV, HASH, 0, 1, 'h01001, 0};
		rows[12] = '{KIND_IN, DEV, HASH, 1, 0, 'h00210, 0};
		repeat (16) @(posedge clk);
		#1;
		n_rst = 1'b1;
		for (n = 0; n < 5; n++)
			check_value(pulse_name[n], cnt[n], 0);
		check_value("o_block_ready", 32'(o_block_ready), 0);
		for (n = 0; n < N_ROWS; n++)
			run_row(n);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/packet_decoder.sv
`default_nettype none

module packet_decoder (
	input wire logic clk,
	input wire logic n_rst,
	input wire logic i_rx_strobe,
	input wire logic [7:0] i_rx_data,
	input wire logic i_eop,
	input wire pd_pkg::byte_idx_t i_rd_addr,
	output logic [7:0] o_rd_data,
	output logic o_host_ready,
	output logic o_ack,
	output logic o_nack,
	output logic o_p_error,
	output logic o_quit_hash,
	output logic o_block_ready
);

	pd_pkg::byte_idx_t byte_count;
	logic packet_done;
	logic cnt_up;
	logic clr_cnt;

	pd_wr_if wr_bus ();

	pd_controller u_ctrl (
		.clk(clk),
		.n_rst(n_rst),
		.i_rx_strobe(i_rx_strobe),
		.i_rx_data(i_rx_data),
		.i_eop(i_eop),
		.i_byte_count(byte_count),
		.i_packet_done(packet_done),
		.o_cnt_up(cnt_up),
		.o_clr_cnt(clr_cnt),
		.o_host_ready(o_host_ready),
		.o_ack(o_ack),
		.o_nack(o_nack),
		.o_p_error(o_p_error),
		.o_quit_hash(o_quit_hash),
		.wr(wr_bus.ctrl)
	);

	pd_byte_counter u_cnt (
		.clk(clk),
		.n_rst(n_rst),
		.i_cnt_up(cnt_up),
		.i_clr_cnt(clr_cnt),
		.o_byte_count(byte_count),
		.o_packet_done(packet_done)
	);

	pd_block_buffer u_buf (
		.clk(clk),
		.n_rst(n_rst),
		.wr(wr_bus.buffer),
		.i_rd_addr(i_rd_addr),
		.o_rd_data(o_rd_data),
		.o_block_ready(o_block_ready)
	);

endmodule

`default_nettype wire

// File: rtl/pd_block_buffer.sv
`default_nettype none

`include "pd_cfg.svh"

module pd_block_buffer (
	input wire logic clk,
	input wire logic n_rst,
	pd_wr_if.buffer wr,
	input wire pd_pkg::byte_idx_t i_rd_addr,
	output logic [7:0] o_rd_data,
	output logic o_block_ready
);

	logic [7:0] mem [`PD_BLOCK_BYTES];

	always_ff @(posedge clk) begin
		if (wr.wr_en)
			mem[wr.wr_idx] <= wr.wr_data;
	end

	// Host side read, no latency
	assign o_rd_data = mem[i_rd_addr];

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			o_block_ready <= 1'b0;
		end else if (wr.new_block) begin
			o_block_ready <= 1'b1;
		end else if (wr.wr_en && (wr.wr_idx == '0)) begin
			o_block_ready <= 1'b0; // Next block has started
		end
	end

endmodule

`default_nettype wire

// File: rtl/pd_byte_counter.sv
`default_nettype none

`include "pd_cfg.svh"

module pd_byte_counter (
	input wire logic clk,
	input wire logic n_rst,
	input wire logic i_cnt_up,
	input wire logic i_clr_cnt,
	output pd_pkg::byte_idx_t o_byte_count,
	output logic o_packet_done
);

	localparam pd_pkg::byte_idx_t LAST_IDX = pd_pkg::byte_idx_t'(`PD_PKT_BYTES - 1);

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			o_byte_count <= '0;
		end else if (i_clr_cnt) begin
			o_byte_count <= '0;
		end else if (i_cnt_up) begin
			if (o_byte_count == LAST_IDX)
				o_byte_count <= '0; // Wrap after the last payload byte
			else
				o_byte_count <= o_byte_count + 1'b1;
		end
	end

	// High during the write of the last byte
	assign o_packet_done = (o_byte_count == LAST_IDX);

endmodule

`default_nettype wire

// File: rtl/pd_controller.sv
`default_nettype none

`include "pd_cfg.svh"

module pd_controller (
	input wire logic clk,
	input wire logic n_rst,
	input wire logic i_rx_strobe,
	input wire logic [7:0] i_rx_data,
	input wire logic i_eop,
	input wire pd_pkg::byte_idx_t i_byte_count,
	input wire logic i_packet_done,
	output logic o_cnt_up,
	output logic o_clr_cnt,
	output logic o_host_ready,
	output logic o_ack,
	output logic o_nack,
	output logic o_p_error,
	output logic o_quit_hash,
	pd_wr_if.ctrl wr
);

	typedef enum logic [4:0] {
		IDLE, READ_PID, IN_PID, WAIT_ADDRESS_IN, READ_ADDRESS_IN, VALID_ADDRESS_IN,
		SEND_TRANSFER_PACKET, EOP_WAIT, OUT_PID, WAIT_ADDRESS_OUT, READ_ADDRESS_OUT,
		VALID_ADDRESS_OUT, OUT_EOP_WAIT, QUIT1, WAIT_DATA_TYPE, CHECK_DATA_TYPE,
		INTERRUPT, INTERRUPT_WAIT_EOP, PACKET_1_WAIT, WRITE_PACKET_1, WAIT_EOP_PACKET,
		QUIT2, PACKET_2_WAIT, WRITE_PACKET_2, WAIT_EOP_BLOCK, NEW_BLOCK, WAIT_EOP_END,
		TRANSMIT_ACK, ERROR, ERROR_EOP_WAIT, ERROR_EOP_END, TRANSMIT_NACK
	} state_e;

	state_e state;
	state_e next_state;
	logic [7:0] rx_byte;
	logic valid_addr;
	logic pid_ok;
	logic addr_match;

	// Byte held for decode in the following state
	always_ff @(posedge clk) begin
		if (i_rx_strobe)
			rx_byte <= i_rx_data;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= IDLE;
			valid_addr <= 1'b0;
		end else begin
			state <= next_state;
			if (state == VALID_ADDRESS_OUT)
				valid_addr <= 1'b1;
		end
	end

	assign pid_ok = (rx_byte[3:0] == ~rx_byte[7:4]);
	assign addr_match = (rx_byte[7:1] == `PD_DEV_ADDR);

	always_comb begin
		next_state = state;
		case (state)
			IDLE: if (i_rx_strobe) next_state = READ_PID;
			READ_PID: begin
				if (!pid_ok) begin
					next_state = ERROR;
				end else begin
					case (pd_pkg::pid_e'(rx_byte))
						pd_pkg::PID_IN: next_state = IN_PID;
						pd_pkg::PID_OUT: next_state = OUT_PID;
						pd_pkg::PID_DATA0: next_state = valid_addr ? QUIT1 : EOP_WAIT;
						pd_pkg::PID_DATA1: next_state = valid_addr ? QUIT2 : EOP_WAIT;
						default: next_state = EOP_WAIT; // Ignored, no response
					endcase
				end
			end
			IN_PID: next_state = WAIT_ADDRESS_IN;
			WAIT_ADDRESS_IN: if (i_rx_strobe) next_state = READ_ADDRESS_IN;
			READ_ADDRESS_IN: next_state = addr_match ? VALID_ADDRESS_IN : OUT_EOP_WAIT;
			VALID_ADDRESS_IN: if (i_eop) next_state = SEND_TRANSFER_PACKET;
			SEND_TRANSFER_PACKET: next_state = IDLE;
			EOP_WAIT: if (i_eop) next_state = IDLE;
			OUT_PID: next_state = WAIT_ADDRESS_OUT;
			WAIT_ADDRESS_OUT: if (i_rx_strobe) next_state = READ_ADDRESS_OUT;
			READ_ADDRESS_OUT: next_state = addr_match ? VALID_ADDRESS_OUT : OUT_EOP_WAIT;
			VALID_ADDRESS_OUT: next_state = OUT_EOP_WAIT;
			OUT_EOP_WAIT: if (i_eop) next_state = IDLE;
			QUIT1: next_state = WAIT_DATA_TYPE;
			WAIT_DATA_TYPE: if (i_rx_strobe) next_state = CHECK_DATA_TYPE;
			CHECK_DATA_TYPE: begin
				case (pd_pkg::dtype_e'(rx_byte))
					pd_pkg::TYPE_INTERRUPT: next_state = INTERRUPT;
					pd_pkg::TYPE_HASH: next_state = PACKET_1_WAIT;
					default: next_state = ERROR;
				endcase
			end
			INTERRUPT: next_state = INTERRUPT_WAIT_EOP;
			INTERRUPT_WAIT_EOP: if (i_eop) next_state = WAIT_EOP_END;
			PACKET_1_WAIT: if (i_rx_strobe) next_state = WRITE_PACKET_1;
			WRITE_PACKET_1: next_state = i_packet_done ? WAIT_EOP_PACKET : PACKET_1_WAIT;
			WAIT_EOP_PACKET: if (i_eop) next_state = WAIT_EOP_END;
			QUIT2: next_state = PACKET_2_WAIT;
			PACKET_2_WAIT: if (i_rx_strobe) next_state = WRITE_PACKET_2;
			WRITE_PACKET_2: next_state = i_packet_done ? WAIT_EOP_BLOCK : PACKET_2_WAIT;
			WAIT_EOP_BLOCK: if (i_eop) next_state = NEW_BLOCK;
			NEW_BLOCK: next_state = WAIT_EOP_END;
			WAIT_EOP_END: if (!i_eop) next_state = TRANSMIT_ACK;
			TRANSMIT_ACK: next_state = IDLE;
			ERROR: next_state = ERROR_EOP_WAIT;
			ERROR_EOP_WAIT: if (i_eop) next_state = ERROR_EOP_END;
			ERROR_EOP_END: if (!i_eop) next_state = TRANSMIT_NACK;
			TRANSMIT_NACK: next_state = IDLE;
			default: next_state = IDLE;
		endcase
	end

	// Moore outputs
	assign o_host_ready = (state == SEND_TRANSFER_PACKET);
	assign o_ack = (state == TRANSMIT_ACK);
	assign o_p_error = (state == ERROR);
	assign o_nack = (state == ERROR) || (state == TRANSMIT_NACK);
	assign o_quit_hash = (state == QUIT1) || (state == QUIT2) || (state == INTERRUPT);
	assign o_cnt_up = (state == WRITE_PACKET_1) || (state == WRITE_PACKET_2);
	assign o_clr_cnt = (state == QUIT1) || (state == QUIT2) || (state == NEW_BLOCK); // Fresh count per packet

	assign wr.wr_en = o_cnt_up;
	assign wr.wr_data = rx_byte;
	assign wr.new_block = (state == NEW_BLOCK);

	// Second packet lands in the upper half
	assign wr.wr_idx = (state == WRITE_PACKET_2) ?
		i_byte_count + pd_pkg::byte_idx_t'(`PD_PKT_BYTES) : i_byte_count;

endmodule

`default_nettype wire

// File: rtl/pd_wr_if.sv
`default_nettype none

interface pd_wr_if;

	logic wr_en; // One byte per strobe
	pd_pkg::byte_idx_t wr_idx;
	logic [7:0] wr_data;
	logic new_block; // Second packet done

	modport ctrl (
		output wr_en,
		output wr_idx,
		output wr_data,
		output new_block
	);

	modport buffer (
		input wr_en,
		input wr_idx,
		input wr_data,
		input new_block
	);

endinterface

`default_nettype wire

// File: rtl/pd_pkg.sv
`default_nettype none

`include "pd_cfg.svh"

package pd_pkg;

	// Handled token codes
	typedef enum logic [7:0] {
		PID_IN    = `PD_PID_IN,
		PID_OUT   = `PD_PID_OUT,
		PID_DATA0 = `PD_PID_DATA0,
		PID_DATA1 = `PD_PID_DATA1
	} pid_e;

	typedef enum logic [7:0] {
		TYPE_INTERRUPT = `PD_TYPE_INTERRUPT,
		TYPE_HASH      = `PD_TYPE_HASH
	} dtype_e;

	// Byte slot in the block buffer
	typedef logic [$clog2(`PD_BLOCK_BYTES)-1:0] byte_idx_t;

endpackage

`default_nettype wire

// File: include/pd_cfg.svh
`ifndef PD_CFG_SVH
`define PD_CFG_SVH

// Address byte carries this in bits 7 to 1
`define PD_DEV_ADDR 7'b1100001

// Token codes, low nibble is the complement of the high nibble
`define PD_PID_IN    8'h69
`define PD_PID_OUT   8'hE1
`define PD_PID_DATA0 8'hC3
`define PD_PID_DATA1 8'h4B

// First byte of a DATA0 payload
`define PD_TYPE_INTERRUPT 8'h00
`define PD_TYPE_HASH      8'hFF

// Two data packets make one block
`define PD_PKT_BYTES   64
`define PD_BLOCK_BYTES 128

`endif
